// File: source/branch_pkg.sv
`default_nettype none

package branch_pkg;

    // Buffer indexing
    // Word-aligned PCs, so the two lowest bits carry no information
    localparam int INDEX_WIDTH = 6;
    localparam int INDEX_LSB = 2;
    localparam int TABLE_DEPTH = 1 << INDEX_WIDTH;

    // Global history selects one predictor per entry
    localparam int HISTORY_WIDTH = 2;
    localparam int PREDICTORS_PER_ENTRY = 1 << HISTORY_WIDTH;

    // PC and target width
    localparam int XLEN = 32;

    // Saturating counters
    // Upper bit is the taken prediction
    localparam int COUNTER_WIDTH = 2;
    // Strongly not taken
    localparam logic [COUNTER_WIDTH-1:0] COUNTER_RESET = '0;

    // Branch operation at execute
    typedef enum logic [1:0] {
        // No control transfer this cycle
        BR_NONE = 2'b00,
        // Conditional, direction from the ALU compare
        BR_COND = 2'b01,
        // Unconditional, always taken
        BR_JUMP = 2'b10
    } branch_op_t;

endpackage

`default_nettype wire

// File: source/local_predictor.sv
`timescale 1ns/10ps
`default_nettype none

module local_predictor
    import branch_pkg::*;
(
    input  logic clk_i,
    input  logic reset_i,
    input  logic enable_i,
    input  logic taken_i,
    output logic pred_o
);

    // Counter state, 0 strongly not taken up to all ones strongly taken
    logic [COUNTER_WIDTH-1:0] count_q;

    // Reset wins over counting
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q <= COUNTER_RESET;
        end else if (enable_i) begin
            if (taken_i) begin
                // Saturate at the top
                if (count_q != {COUNTER_WIDTH{1'b1}}) begin
                    count_q <= count_q + 1'b1;
                end
            end else begin
                // Saturate at zero
                if (count_q != '0) begin
                    count_q <= count_q - 1'b1;
                end
            end
        end
    end

    // Taken once in the upper half
    assign pred_o = count_q[COUNTER_WIDTH-1];

endmodule

`default_nettype wire

// File: source/branching_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module branching_buffer
    import branch_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     reset_i,

    // Fetch lookup
    input  logic [INDEX_WIDTH-1:0]   fetch_index_i,
    input  logic [HISTORY_WIDTH-1:0] history_i,

    // Execute-side target read for the reallocation compare
    input  logic [INDEX_WIDTH-1:0]   exec_index_i,

    // Registered update request
    input  logic                     upd_valid_i,
    input  logic                     upd_taken_i,
    input  logic                     upd_new_target_i,
    input  logic [INDEX_WIDTH-1:0]   upd_index_i,
    input  logic [XLEN-1:0]          upd_target_i,
    input  logic [HISTORY_WIDTH-1:0] upd_history_i,

    output logic                     pc_src_pred_f_o,
    output logic [XLEN-1:0]          pred_pc_target_f_o,
    output logic [XLEN-1:0]          stored_target_o
);

    // Target storage, one word per entry
    logic [XLEN-1:0] target_mem [TABLE_DEPTH];

    // Prediction bits, grouped per entry and indexed by history
    logic [PREDICTORS_PER_ENTRY-1:0] pred_bits [TABLE_DEPTH];

    // One step line per counter, addressed by {index, history}
    logic [TABLE_DEPTH*PREDICTORS_PER_ENTRY-1:0] step_lines;

    // Per-entry clear on reallocation
    logic [TABLE_DEPTH-1:0] entry_reset;

    // Update decode
    // A new target resets the whole entry, so no step is needed then
    always_comb begin
        step_lines = '0;
        entry_reset = '0;
        if (upd_valid_i) begin
            if (upd_new_target_i) begin
                entry_reset[upd_index_i] = 1'b1;
            end else begin
                step_lines[{upd_index_i, upd_history_i}] = 1'b1;
            end
        end
    end

    // Counter array
    for (genvar e = 0; e < TABLE_DEPTH; e++) begin : g_entry
        for (genvar p = 0; p < PREDICTORS_PER_ENTRY; p++) begin : g_pred
            local_predictor local_predictor_inst (
                .clk_i    (clk_i),
                // Global reset or reallocation of this entry
                .reset_i  (reset_i | entry_reset[e]),
                .enable_i (step_lines[e*PREDICTORS_PER_ENTRY + p]),
                .taken_i  (upd_taken_i),
                .pred_o   (pred_bits[e][p])
            );
        end
    end

    // Target write on reallocation
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < TABLE_DEPTH; i++) begin
                target_mem[i] <= '0;
            end
        end else if (upd_valid_i && upd_new_target_i) begin
            target_mem[upd_index_i] <= upd_target_i;
        end
    end

    // Fetch read, same cycle
    assign pc_src_pred_f_o = pred_bits[fetch_index_i][history_i];
    assign pred_pc_target_f_o = target_mem[fetch_index_i];

    // Execute read
    // Does not see a write still pending from the previous branch
    assign stored_target_o = target_mem[exec_index_i];

endmodule

`default_nettype wire

// File: source/global_history.sv
`timescale 1ns/10ps
`default_nettype none

module global_history
    import branch_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  branch_op_t               branch_op_e_i,
    input  logic                     branch_taken_e_i,
    output logic [HISTORY_WIDTH-1:0] history_o
);

    // Most recent outcome sits in bit 0
    logic [HISTORY_WIDTH-1:0] history_q;

    // Only conditional branches carry direction information
    logic shift_en;

    assign shift_en = (branch_op_e_i == BR_COND);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            history_q <= '0;
        end else if (shift_en) begin
            // Oldest outcome drops out of the top
            history_q <= {history_q[HISTORY_WIDTH-2:0], branch_taken_e_i};
        end
    end

    // Feeds fetch selection and the update capture
    assign history_o = history_q;

endmodule

`default_nettype wire

// File: source/branch_resolution.sv
`timescale 1ns/10ps
`default_nettype none

module branch_resolution
    import branch_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic [XLEN-1:0]          pc_e_i,
    input  logic [XLEN-1:0]          pc_target_e_i,
    input  logic [XLEN-1:0]          pred_target_e_i,
    input  branch_op_t               branch_op_e_i,
    input  logic                     branch_taken_e_i,
    input  logic                     pred_taken_e_i,
    input  logic [HISTORY_WIDTH-1:0] history_i,
    input  logic [XLEN-1:0]          stored_target_i,
    output logic                     mispredict_e_o,
    output logic                     upd_valid_o,
    output logic                     upd_taken_o,
    output logic                     upd_new_target_o,
    output logic [INDEX_WIDTH-1:0]   upd_index_o,
    output logic [XLEN-1:0]          upd_target_o,
    output logic [HISTORY_WIDTH-1:0] upd_history_o
);

    logic is_branch;
    logic eff_taken;
    logic dir_wrong;
    logic target_wrong;
    logic new_target;

    assign is_branch = (branch_op_e_i != BR_NONE);

    // Jumps always count as taken
    assign eff_taken = (branch_op_e_i == BR_JUMP) ||
                       ((branch_op_e_i == BR_COND) && branch_taken_e_i);

    // Wrong direction, or taken to a different place than predicted
    assign dir_wrong = (eff_taken != pred_taken_e_i);
    assign target_wrong = eff_taken && (pred_target_e_i != pc_target_e_i);
    assign mispredict_e_o = is_branch && (dir_wrong || target_wrong);

    // Entry holds another branch's target, so reallocate
    assign new_target = (stored_target_i != pc_target_e_i);

    // Strobe
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            upd_valid_o <= 1'b0;
        end else begin
            upd_valid_o <= is_branch;
        end
    end

    // Request payload, qualified by the strobe downstream
    always_ff @(posedge clk_i) begin
        if (is_branch) begin
            upd_taken_o <= eff_taken;
            upd_new_target_o <= new_target;
            upd_index_o <= pc_e_i[INDEX_LSB +: INDEX_WIDTH];
            upd_target_o <= pc_target_e_i;
            // History before this branch shifts in
            upd_history_o <= history_i;
        end
    end

endmodule

`default_nettype wire

// File: source/branch_predictor_top.sv
`timescale 1ns/10ps
`default_nettype none

module branch_predictor_top
    import branch_pkg::*;
(
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic [XLEN-1:0] pc_f_i,
    input  logic [XLEN-1:0] pc_e_i,
    input  logic [XLEN-1:0] pc_target_e_i,
    input  logic [XLEN-1:0] pred_target_e_i,
    input  branch_op_t      branch_op_e_i,
    input  logic            branch_taken_e_i,
    input  logic            pred_taken_e_i,
    output logic            pc_src_pred_f_o,
    output logic            mispredict_e_o,
    output logic [XLEN-1:0] pred_pc_target_f_o
);

    logic [HISTORY_WIDTH-1:0] history;
    logic [XLEN-1:0]          stored_target;

    // Update request between resolution and buffer
    logic                     upd_valid;
    logic                     upd_taken;
    logic                     upd_new_target;
    logic [INDEX_WIDTH-1:0]   upd_index;
    logic [XLEN-1:0]          upd_target;
    logic [HISTORY_WIDTH-1:0] upd_history;

    global_history global_history_inst (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .branch_op_e_i    (branch_op_e_i),
        .branch_taken_e_i (branch_taken_e_i),
        .history_o        (history)
    );

    branch_resolution branch_resolution_inst (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .pc_e_i           (pc_e_i),
        .pc_target_e_i    (pc_target_e_i),
        .pred_target_e_i  (pred_target_e_i),
        .branch_op_e_i    (branch_op_e_i),
        .branch_taken_e_i (branch_taken_e_i),
        .pred_taken_e_i   (pred_taken_e_i),
        .history_i        (history),
        .stored_target_i  (stored_target),
        .mispredict_e_o   (mispredict_e_o),
        .upd_valid_o      (upd_valid),
        .upd_taken_o      (upd_taken),
        .upd_new_target_o (upd_new_target),
        .upd_index_o      (upd_index),
        .upd_target_o     (upd_target),
        .upd_history_o    (upd_history)
    );

    // Both lookups index on the word-aligned PC bits
    branching_buffer branching_buffer_inst (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .fetch_index_i      (pc_f_i[INDEX_LSB +: INDEX_WIDTH]),
        .history_i          (history),
        .exec_index_i       (pc_e_i[INDEX_LSB +: INDEX_WIDTH]),
        .upd_valid_i        (upd_valid),
        .upd_taken_i        (upd_taken),
        .upd_new_target_i   (upd_new_target),
        .upd_index_i        (upd_index),
        .upd_target_i       (upd_target),
        .upd_history_i      (upd_history),
        .pc_src_pred_f_o    (pc_src_pred_f_o),
        .pred_pc_target_f_o (pred_pc_target_f_o),
        .stored_target_o    (stored_target)
    );

endmodule

`default_nettype wire

// File: sim/branch_predictor_tb.sv
`timescale 1ns/10ps
`default_nettype none

module branch_predictor_tb
    import branch_pkg::*;
;

    localparam int CLK_PERIOD = 20;
    // Cycle budget per test
    localparam int RESET_LEN = 7;
    localparam int IDLE_LEN = TABLE_DEPTH + 4;
    localparam int FIRST_LEN = 3;
    localparam int SAT_LEN = 14;
    localparam int HIST_LEN = 13;
    localparam int REALLOC_LEN = 3;
    localparam int RANDOM_LEN = 200;
    localparam int TOTAL_LEN = RESET_LEN + IDLE_LEN + FIRST_LEN + SAT_LEN + HIST_LEN
                             + REALLOC_LEN + RANDOM_LEN;
    localparam int TIMEOUT_NS = (TOTAL_LEN + 100) * CLK_PERIOD;

    logic            clk_i;
    logic            reset_i;
    logic [XLEN-1:0] pc_f_i;
    logic [XLEN-1:0] pc_e_i;
    logic [XLEN-1:0] pc_target_e_i;
    logic [XLEN-1:0] pred_target_e_i;
    branch_op_t      branch_op_e_i;
    logic            branch_taken_e_i;
    logic            pred_taken_e_i;
    logic            pc_src_pred_f_o;
    logic            mispredict_e_o;
    logic [XLEN-1:0] pred_pc_target_f_o;

    // Reference model state
    logic [COUNTER_WIDTH-1:0] m_count [TABLE_DEPTH][PREDICTORS_PER_ENTRY];
    logic [XLEN-1:0]          m_target [TABLE_DEPTH];
    logic [HISTORY_WIDTH-1:0] m_hist;
    // Update request waiting in the resolution register
    logic                     pend_valid;
    logic                     pend_taken;
    logic                     pend_new;
    logic [INDEX_WIDTH-1:0]   pend_index;
    logic [XLEN-1:0]          pend_target;
    logic [HISTORY_WIDTH-1:0] pend_hist;

    int error_count;
    int check_count;

    branch_predictor_top branch_predictor_top_inst (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .pc_f_i             (pc_f_i),
        .pc_e_i             (pc_e_i),
        .pc_target_e_i      (pc_target_e_i),
        .pred_target_e_i    (pred_target_e_i),
        .branch_op_e_i      (branch_op_e_i),
        .branch_taken_e_i   (branch_taken_e_i),
        .pred_taken_e_i     (pred_taken_e_i),
        .pc_src_pred_f_o    (pc_src_pred_f_o),
        .mispredict_e_o     (mispredict_e_o),
        .pred_pc_target_f_o (pred_pc_target_f_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("mismatch %s: got %h expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    // Model of one clock edge
    task automatic model_edge(input branch_op_t op, input logic [INDEX_WIDTH-1:0] ei,
                              input logic eff, input logic taken, input logic [XLEN-1:0] tgt);
        logic new_tgt;
        // Compare against the table before the pending write lands
        new_tgt = (m_target[ei] != tgt);
        if (pend_valid) begin
            if (pend_new) begin
                m_target[pend_index] = pend_target;
                for (int k = 0; k < PREDICTORS_PER_ENTRY; k++) begin
                    m_count[pend_index][k] = COUNTER_RESET;
                end
            end else if (pend_taken && m_count[pend_index][pend_hist] != 2'd3) begin
                m_count[pend_index][pend_hist]++;
            end else if (!pend_taken && m_count[pend_index][pend_hist] != 2'd0) begin
                m_count[pend_index][pend_hist]--;
            end
        end
        pend_valid = (op != BR_NONE);
        pend_taken = eff;
        pend_new = new_tgt;
        pend_index = ei;
        pend_target = tgt;
        pend_hist = m_hist;
        // Only conditionals shift the history
        if (op == BR_COND) begin
            m_hist = {m_hist[HISTORY_WIDTH-2:0], taken};
        end
    endtask

    // One cycle with an execute strobe, prediction carried from the model
    task automatic run_cycle(input branch_op_t op, input logic [XLEN-1:0] pc_e,
                             input logic taken, input logic [XLEN-1:0] tgt,
                             input logic [XLEN-1:0] pc_f);
        logic [INDEX_WIDTH-1:0] ei;
        logic [INDEX_WIDTH-1:0] fi;
        logic p_taken;
        logic eff;
        logic exp_mis;
        @(negedge clk_i);
        ei = pc_e[INDEX_LSB +: INDEX_WIDTH];
        fi = pc_f[INDEX_LSB +: INDEX_WIDTH];
        p_taken = m_count[ei][m_hist][COUNTER_WIDTH-1];
        pc_f_i = pc_f;
        pc_e_i = pc_e;
        branch_op_e_i = op;
        branch_taken_e_i = taken;
        pc_target_e_i = tgt;
        pred_taken_e_i = p_taken;
        pred_target_e_i = m_target[ei];
        eff = (op == BR_JUMP) || ((op == BR_COND) && taken);
        exp_mis = (op != BR_NONE) && ((eff != p_taken) || (eff && m_target[ei] != tgt));
        #1;
        compare_value("mispredict_e_o", 32'(mispredict_e_o), 32'(exp_mis));
        compare_value("pc_src_pred_f_o", 32'(pc_src_pred_f_o),
                      32'(m_count[fi][m_hist][COUNTER_WIDTH-1]));
        compare_value("pred_pc_target_f_o", pred_pc_target_f_o, m_target[fi]);
        @(posedge clk_i);
        model_edge(op, ei, eff, taken, tgt);
    endtask

    task automatic idle_cycle(input logic [XLEN-1:0] pc_f);
        run_cycle(BR_NONE, '0, 1'b0, '0, pc_f);
    endtask

    // Every entry not taken with target 0
    task automatic reset_state_test();
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            idle_cycle(32'(i) << INDEX_LSB);
        end
    endtask

    task automatic first_taken_test();
        run_cycle(BR_COND, 32'h40, 1'b1, 32'h2000, 32'h40);
        repeat (2) idle_cycle(32'h40);
    endtask

    task automatic saturation_test();
        // Allocation, then steps toward taken
        repeat (6) run_cycle(BR_COND, 32'h80, 1'b1, 32'h3000, 32'h80);
        repeat (2) idle_cycle(32'h80);
        // One not-taken from saturation
        run_cycle(BR_COND, 32'h80, 1'b0, 32'h3000, 32'h80);
        repeat (2) idle_cycle(32'h80);
        // Taken branches elsewhere restore history 11
        repeat (2) run_cycle(BR_COND, 32'hc0, 1'b1, 32'h3400, 32'h80);
        idle_cycle(32'h80);
    endtask

    task automatic history_test();
        // Jumps allocate and count without moving the history
        repeat (4) run_cycle(BR_JUMP, 32'h100, 1'b0, 32'h4000, 32'h100);
        run_cycle(BR_COND, 32'h140, 1'b0, 32'h4400, 32'h100);
        repeat (2) idle_cycle(32'h100);
        repeat (3) run_cycle(BR_JUMP, 32'h100, 1'b1, 32'h4000, 32'h100);
        run_cycle(BR_COND, 32'h140, 1'b1, 32'h4400, 32'h100);
        repeat (2) idle_cycle(32'h100);
    endtask

    // Trained entry moves to a new target
    task automatic realloc_test();
        run_cycle(BR_COND, 32'h80, 1'b1, 32'h5000, 32'h80);
        repeat (2) idle_cycle(32'h80);
    endtask

    task automatic random_test();
        logic [XLEN-1:0] pc_e;
        logic [XLEN-1:0] pc_f;
        logic [XLEN-1:0] tgt;
        branch_op_t op;
        for (int n = 0; n < RANDOM_LEN; n++) begin
            // Bit 8 aliases onto the same index
            pc_e = ($urandom_range(0, 7) << INDEX_LSB) | ($urandom_range(0, 1) << 8);
            pc_f = ($urandom_range(0, 7) << INDEX_LSB) | ($urandom_range(0, 1) << 8);
            tgt = $urandom_range(1, 4) << 12;
            op = branch_op_t'($urandom_range(0, 2));
            run_cycle(op, pc_e, 1'($urandom_range(0, 1)), tgt, pc_f);
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        void'($urandom(56462));
        error_count = 0;
        check_count = 0;
        clk_i = 1'b0;
        reset_i = 1'b1;
        pc_f_i = '0;
        pc_e_i = '0;
        pc_target_e_i = '0;
        pred_target_e_i = '0;
        branch_op_e_i = BR_NONE;
        branch_taken_e_i = 1'b0;
        pred_taken_e_i = 1'b0;
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            m_target[i] = '0;
            for (int k = 0; k < PREDICTORS_PER_ENTRY; k++) begin
                m_count[i][k] = COUNTER_RESET;
            end
        end
        m_hist = '0;
        pend_valid = 1'b0;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        reset_state_test();
        first_taken_test();
        saturation_test();
        history_test();
        realloc_test();
        random_test();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
source/branch_pkg.sv
source/local_predictor.sv
source/branching_buffer.sv
source/global_history.sv
source/branch_resolution.sv
source/branch_predictor_top.sv
sim/branch_predictor_tb.sv

// File: Makefile
TOP = branch_predictor_tb

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sources.f -o sim_bin
	./obj_dir/sim_bin | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
